// File: filelist.f
verilog/udp_tx_pkg.sv
verilog/udp_sync_fifo.sv
verilog/udp_len_counter.sv
verilog/udp_csum_accum.sv
verilog/udp_csum_finish.sv
verilog/udp_tx_ctrl.sv
verilog/udp_tx.sv
testbench/udp_tx_assert.sv
testbench/tb_udp_tx.sv

// File: Bender.yml
package:
  name: udp_tx

sources:
  - verilog/udp_tx_pkg.sv
  - verilog/udp_sync_fifo.sv
  - verilog/udp_len_counter.sv
  - verilog/udp_csum_accum.sv
  - verilog/udp_csum_finish.sv
  - verilog/udp_tx_ctrl.sv
  - verilog/udp_tx.sv
  - target: test
    files:
      - testbench/udp_tx_assert.sv
      - testbench/tb_udp_tx.sv

// File: testbench/tb_udp_tx.sv
`timescale 1ns/1ps

module tb_udp_tx;
    import udp_tx_pkg::*;

    localparam int NUM_PKTS       = 40;
    localparam int WAIT_LIMIT     = 20000;
    localparam int MAC_OFF_PKT    = 10;
    localparam int MAC_OFF_CYCLES = 30;

    logic              tx_axis_aclk;
    logic              tx_axis_aresetn;
    logic [31:0]       src_ip_addr;
    logic [31:0]       dst_ip_addr;
    logic [15:0]       udp_src_port;
    logic [15:0]       udp_dst_port;
    logic [DATA_W-1:0] udp_tx_axis_tdata;
    logic [KEEP_W-1:0] udp_tx_axis_tkeep;
    logic              udp_tx_axis_tvalid;
    logic              udp_tx_axis_tlast;
    logic              udp_tx_axis_tready;
    logic [DATA_W-1:0] ip_tx_axis_tdata;
    logic [KEEP_W-1:0] ip_tx_axis_tkeep;
    logic              ip_tx_axis_tvalid;
    logic              ip_tx_axis_tlast;
    logic              ip_tx_axis_tready;
    logic              mac_exist;
    logic              udp_not_empty;

    integer            seed;
    integer            stall_seed;
    int                value_errs;
    int                other_errs;
    int                pkts_seen;
    int                beats_seen;
    int                waited;

    // expected output beats, header first for each packet
    logic [DATA_W-1:0] exp_data [$];
    logic [KEEP_W-1:0] exp_keep [$];
    logic              exp_last [$];
    logic              exp_hdr  [$];
    logic [7:0]        pay      [$];

    udp_tx i_udp_tx (.*);

    bind udp_tx udp_tx_assert i_udp_tx_assert (
        .tx_axis_aclk       (tx_axis_aclk),
        .tx_axis_aresetn    (tx_axis_aresetn),
        .mac_exist          (mac_exist),
        .udp_tx_axis_tready (udp_tx_axis_tready),
        .ip_tx_axis_tdata   (ip_tx_axis_tdata),
        .ip_tx_axis_tkeep   (ip_tx_axis_tkeep),
        .ip_tx_axis_tvalid  (ip_tx_axis_tvalid),
        .ip_tx_axis_tlast   (ip_tx_axis_tlast),
        .ip_tx_axis_tready  (ip_tx_axis_tready)
    );

    initial begin
        tx_axis_aclk = 1'b0;
        forever begin
            #4 tx_axis_aclk = ~tx_axis_aclk;
        end
    end

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        value_errs++;
        $display("ERROR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    endtask

    task automatic print_counts();
        $display("errors: value %0d, other %0d, assertion %0d; packets %0d, beats %0d",
                 value_errs, other_errs, i_udp_tx.i_udp_tx_assert.fail_cnt,
                 pkts_seen, beats_seen);
    endtask

    task automatic abort_run(input string what);
        other_errs++;
        $display("%s at t=%0t", what, $time);
        print_counts();
        $display("TB FAILED");
        $finish;
    endtask

    // pseudo-header, udp header with zero checksum, zero-padded payload
    function automatic logic [15:0] model_checksum(input int n);
        logic [31:0] acc;
        logic [15:0] udp_len;
        logic [15:0] word;
        udp_len = 16'(n + UDP_HDR_BYTES);
        acc = 32'(src_ip_addr[31:16]) + src_ip_addr[15:0] + dst_ip_addr[31:16]
            + dst_ip_addr[15:0];
        acc = acc + UDP_PROTO + udp_len + udp_src_port + udp_dst_port + udp_len;
        for (int i = 0; i < n; i += 2) begin
            word[15:8] = pay[i];
            word[7:0]  = (i + 1 < n) ? pay[i + 1] : 8'h00;
            acc = acc + word;
        end
        while (acc[31:16] != 16'h0) begin
            acc = {16'h0, acc[15:0]} + acc[31:16];
        end
        return ~acc[15:0];
    endfunction

    task automatic push_header(input int n);
        logic [DATA_W-1:0] hdr;
        logic [15:0]       len;
        logic [15:0]       csum;
        len  = 16'(n + UDP_HDR_BYTES);
        csum = model_checksum(n);
        // lane 0 goes first on the wire, fields big-endian
        hdr[7:0]   = udp_src_port[15:8];
        hdr[15:8]  = udp_src_port[7:0];
        hdr[23:16] = udp_dst_port[15:8];
        hdr[31:24] = udp_dst_port[7:0];
        hdr[39:32] = len[15:8];
        hdr[47:40] = len[7:0];
        hdr[55:48] = csum[15:8];
        hdr[63:56] = csum[7:0];
        exp_data.push_back(hdr);
        exp_keep.push_back('1);
        exp_last.push_back(1'b0);
        exp_hdr.push_back(1'b1);
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic drive_beat(input logic [DATA_W-1:0] data, input logic [KEEP_W-1:0] keep,
                              input logic last);
        int count;
        udp_tx_axis_tdata  = data;
        udp_tx_axis_tkeep  = keep;
        udp_tx_axis_tlast  = last;
        udp_tx_axis_tvalid = 1'b1;
        count = 0;
        @(posedge tx_axis_aclk);
        while (!udp_tx_axis_tready) begin
            count++;
            if (count > WAIT_LIMIT) begin
                abort_run("timeout waiting for udp_tx_axis_tready");
            end
            @(posedge tx_axis_aclk);
        end
        @(negedge tx_axis_aclk);
    endtask

    task automatic send_packet(input int idx);
        int                n;
        int                beats;
        int                gap;
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        n = 1 + ($unsigned($random(seed)) % MAX_PAYLOAD_BYTES);
        pay.delete();
        for (int i = 0; i < n; i++) begin
            pay.push_back(8'($random(seed)));
        end
        push_header(n);
        beats = (n + KEEP_W - 1) / KEEP_W;
        for (int b = 0; b < beats; b++) begin
            // dead lanes carry junk that must not reach the checksum
            data[31:0]  = $random(seed);
            data[63:32] = $random(seed);
            keep = '0;
            for (int k = 0; k < KEEP_W; k++) begin
                if (KEEP_W * b + k < n) begin
                    data[8*k +: 8] = pay[KEEP_W * b + k];
                    keep[k] = 1'b1;
                end
            end
            exp_data.push_back(data);
            exp_keep.push_back(keep);
            exp_last.push_back(b == beats - 1);
            exp_hdr.push_back(1'b0);
            gap = (($unsigned($random(seed)) % 8) == 0) ? 1 + $unsigned($random(seed)) % 3 : 0;
            if (gap > 0) begin
                udp_tx_axis_tvalid = 1'b0;
                repeat (gap) @(negedge tx_axis_aclk);
            end
            if (idx == MAC_OFF_PKT && b == 0) begin
                mac_exist          = 1'b0;
                udp_tx_axis_tdata  = data;
                udp_tx_axis_tkeep  = keep;
                udp_tx_axis_tlast  = (b == beats - 1);
                udp_tx_axis_tvalid = 1'b1;
                repeat (MAC_OFF_CYCLES) begin
                    @(posedge tx_axis_aclk);
                    if (udp_tx_axis_tready) begin
                        report_value("udp_tx_axis_tready", 1, 0);
                    end
                end
                @(negedge tx_axis_aclk);
                mac_exist = 1'b1;
            end
            drive_beat(data, keep, b == beats - 1);
        end
        udp_tx_axis_tvalid = 1'b0;
    endtask

    task automatic check_out_beat();
        logic [DATA_W-1:0] e_data;
        logic [KEEP_W-1:0] e_keep;
        logic              e_last;
        logic              e_hdr;
        logic [DATA_W-1:0] mask;
        if (exp_data.size() == 0) begin
            other_errs++;
            $display("output beat at t=%0t with no beat expected", $time);
            return;
        end
        e_data = exp_data.pop_front();
        e_keep = exp_keep.pop_front();
        e_last = exp_last.pop_front();
        e_hdr  = exp_hdr.pop_front();
        if (e_hdr) begin
            if (ip_tx_axis_tdata[31:0] !== e_data[31:0]) begin
                report_value("ip_tx_axis_tdata ports", ip_tx_axis_tdata[31:0], e_data[31:0]);
            end
            if (ip_tx_axis_tdata[47:32] !== e_data[47:32]) begin
                report_value("ip_tx_axis_tdata length", ip_tx_axis_tdata[47:32],
                             e_data[47:32]);
            end
            if (ip_tx_axis_tdata[63:48] !== e_data[63:48]) begin
                report_value("ip_tx_axis_tdata checksum", ip_tx_axis_tdata[63:48],
                             e_data[63:48]);
            end
        end else begin
            mask = '0;
            for (int k = 0; k < KEEP_W; k++) begin
                mask[8*k +: 8] = {8{e_keep[k]}};
            end
            if ((ip_tx_axis_tdata & mask) !== (e_data & mask)) begin
                report_value("ip_tx_axis_tdata", ip_tx_axis_tdata & mask, e_data & mask);
            end
        end
        if (ip_tx_axis_tkeep !== e_keep) begin
            report_value("ip_tx_axis_tkeep", ip_tx_axis_tkeep, e_keep);
        end
        if (ip_tx_axis_tlast !== e_last) begin
            report_value("ip_tx_axis_tlast", ip_tx_axis_tlast, e_last);
        end
        beats_seen++;
        if (e_last) begin
            pkts_seen++;
        end
    endtask

    // sink with random stalls, own random stream
    initial begin
        @(posedge tx_axis_aresetn);
        forever begin
            @(negedge tx_axis_aclk);
            ip_tx_axis_tready = ($unsigned($random(stall_seed)) % 4) != 0;
            if (ip_tx_axis_tvalid && ip_tx_axis_tready) begin
                check_out_beat();
            end
        end
    end

    initial begin
        seed               = 32'ha3af_716a;
        stall_seed         = 32'ha3af_716a;
        value_errs         = 0;
        other_errs         = 0;
        pkts_seen          = 0;
        beats_seen         = 0;
        tx_axis_aresetn    = 1'b0;
        src_ip_addr        = '0;
        dst_ip_addr        = '0;
        udp_src_port       = '0;
        udp_dst_port       = '0;
        udp_tx_axis_tdata  = '0;
        udp_tx_axis_tkeep  = '0;
        udp_tx_axis_tvalid = 1'b0;
        udp_tx_axis_tlast  = 1'b0;
        ip_tx_axis_tready  = 1'b0;
        mac_exist          = 1'b0;
        repeat (10) @(negedge tx_axis_aclk);
        tx_axis_aresetn = 1'b1;
        @(negedge tx_axis_aclk);
        if (udp_not_empty !== 1'b0) begin
            report_value("udp_not_empty", udp_not_empty, 0);
        end
        if (ip_tx_axis_tvalid !== 1'b0) begin
            report_value("ip_tx_axis_tvalid", ip_tx_axis_tvalid, 0);
        end
        if (ip_tx_axis_tlast !== 1'b0) begin
            report_value("ip_tx_axis_tlast", ip_tx_axis_tlast, 0);
        end
        if (udp_tx_axis_tready !== 1'b0) begin
            report_value("udp_tx_axis_tready", udp_tx_axis_tready, 0);
        end

        src_ip_addr  = $random(seed);
        dst_ip_addr  = $random(seed);
        udp_src_port = 16'($random(seed));
        udp_dst_port = 16'($random(seed));
        mac_exist    = 1'b1;

        // first packet alone, watch the status level rise
        send_packet(0);
        waited = 0;
        while (!udp_not_empty) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("udp_not_empty never rose after the first packet");
            end
            @(negedge tx_axis_aclk);
        end

        for (int p = 1; p < NUM_PKTS; p++) begin
            send_packet(p);
        end

        waited = 0;
        while (pkts_seen < NUM_PKTS) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("timeout waiting for all output packets");
            end
            @(negedge tx_axis_aclk);
        end
        repeat (4) @(negedge tx_axis_aclk);
        if (udp_not_empty !== 1'b0) begin
            report_value("udp_not_empty", udp_not_empty, 0);
        end
        if (exp_data.size() != 0) begin
            other_errs++;
            $display("%0d expected beats never came out", exp_data.size());
        end

        print_counts();
        if (value_errs + other_errs + i_udp_tx.i_udp_tx_assert.fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/udp_tx_assert.sv
`timescale 1ns/1ps

module udp_tx_assert (
    input logic                          tx_axis_aclk,
    input logic                          tx_axis_aresetn,
    input logic                          mac_exist,
    input logic                          udp_tx_axis_tready,
    input logic [udp_tx_pkg::DATA_W-1:0] ip_tx_axis_tdata,
    input logic [udp_tx_pkg::KEEP_W-1:0] ip_tx_axis_tkeep,
    input logic                          ip_tx_axis_tvalid,
    input logic                          ip_tx_axis_tlast,
    input logic                          ip_tx_axis_tready
);
    int fail_cnt = 0;

    // stalled beat must not move
    property hold_while_stalled;
        @(posedge tx_axis_aclk) disable iff (!tx_axis_aresetn)
        ip_tx_axis_tvalid && !ip_tx_axis_tready |=>
            ip_tx_axis_tvalid && $stable(ip_tx_axis_tdata) &&
            $stable(ip_tx_axis_tkeep) && $stable(ip_tx_axis_tlast);
    endproperty

    property no_ready_without_mac;
        @(posedge tx_axis_aclk) !mac_exist |-> !udp_tx_axis_tready;
    endproperty

    property quiet_after_reset;
        @(posedge tx_axis_aclk) !tx_axis_aresetn |=> !ip_tx_axis_tvalid;
    endproperty

    a_hold: assert property (hold_while_stalled) else begin
        fail_cnt++;
        $error("output beat changed while stalled");
    end

    a_mac: assert property (no_ready_without_mac) else begin
        fail_cnt++;
        $error("input ready high while mac_exist low");
    end

    a_reset: assert property (quiet_after_reset) else begin
        fail_cnt++;
        $error("output valid high after reset");
    end

endmodule

// File: verilog/udp_tx.sv
`timescale 1ns/1ps

module udp_tx (
    input  logic [31:0]                    src_ip_addr,
    input  logic [31:0]                    dst_ip_addr,
    input  logic [15:0]                    udp_src_port,
    input  logic [15:0]                    udp_dst_port,
    input  logic                           tx_axis_aclk,
    input  logic                           tx_axis_aresetn,
    input  logic [udp_tx_pkg::DATA_W-1:0]  udp_tx_axis_tdata,
    input  logic [udp_tx_pkg::KEEP_W-1:0]  udp_tx_axis_tkeep,
    input  logic                           udp_tx_axis_tvalid,
    input  logic                           udp_tx_axis_tlast,
    output logic                           udp_tx_axis_tready,
    output logic [udp_tx_pkg::DATA_W-1:0]  ip_tx_axis_tdata,
    output logic [udp_tx_pkg::KEEP_W-1:0]  ip_tx_axis_tkeep,
    output logic                           ip_tx_axis_tvalid,
    output logic                           ip_tx_axis_tlast,
    input  logic                           ip_tx_axis_tready,
    input  logic                           mac_exist,
    output logic                           udp_not_empty
);
    import udp_tx_pkg::*;

    logic              beat_fire;
    logic              last_fire;
    logic [LEN_W-1:0]  pkt_len;
    logic              sum_valid;
    logic [CSUM_W-1:0] pay_sum;
    logic [LEN_W-1:0]  pay_len;

    payload_beat_t     beat_wr_data;
    payload_beat_t     beat_rd_data;
    logic              beat_rd;
    logic              beat_empty;
    logic              payload_afull;

    logic              meta_wr;
    udp_meta_t         meta_wr_data;
    udp_meta_t         meta_rd_data;
    logic              meta_rd;
    logic              meta_empty;
    logic              meta_afull;

    assign beat_wr_data  = '{data: udp_tx_axis_tdata, keep: udp_tx_axis_tkeep,
                             last: udp_tx_axis_tlast};
    // status level for the upper layer
    assign udp_not_empty = ~meta_empty;

    udp_len_counter i_len_counter (
        .tx_axis_aclk    (tx_axis_aclk),
        .tx_axis_aresetn (tx_axis_aresetn),
        .in_valid        (udp_tx_axis_tvalid),
        .in_last         (udp_tx_axis_tlast),
        .in_keep         (udp_tx_axis_tkeep),
        .mac_exist       (mac_exist),
        .payload_afull   (payload_afull),
        .meta_afull      (meta_afull),
        .in_ready        (udp_tx_axis_tready),
        .beat_fire       (beat_fire),
        .last_fire       (last_fire),
        .pkt_len         (pkt_len)
    );

    udp_csum_accum i_csum_accum (
        .tx_axis_aclk    (tx_axis_aclk),
        .tx_axis_aresetn (tx_axis_aresetn),
        .beat_fire       (beat_fire),
        .last_fire       (last_fire),
        .in_data         (udp_tx_axis_tdata),
        .in_keep         (udp_tx_axis_tkeep),
        .pkt_len         (pkt_len),
        .sum_valid       (sum_valid),
        .pay_sum         (pay_sum),
        .pay_len         (pay_len)
    );

    udp_csum_finish i_csum_finish (
        .tx_axis_aclk    (tx_axis_aclk),
        .tx_axis_aresetn (tx_axis_aresetn),
        .sum_valid       (sum_valid),
        .pay_sum         (pay_sum),
        .pay_len         (pay_len),
        .src_ip_addr     (src_ip_addr),
        .dst_ip_addr     (dst_ip_addr),
        .udp_src_port    (udp_src_port),
        .udp_dst_port    (udp_dst_port),
        .meta_wr         (meta_wr),
        .meta_data       (meta_wr_data)
    );

    udp_sync_fifo #(
        .entry_t (payload_beat_t),
        .DEPTH   (PAYLOAD_FIFO_DEPTH)
    ) i_payload_fifo (
        .tx_axis_aclk    (tx_axis_aclk),
        .tx_axis_aresetn (tx_axis_aresetn),
        .wr_en           (beat_fire),
        .wr_data         (beat_wr_data),
        .rd_en           (beat_rd),
        .rd_data         (beat_rd_data),
        .empty           (beat_empty),
        .almost_full     (payload_afull)
    );

    udp_sync_fifo #(
        .entry_t (udp_meta_t),
        .DEPTH   (META_FIFO_DEPTH)
    ) i_meta_fifo (
        .tx_axis_aclk    (tx_axis_aclk),
        .tx_axis_aresetn (tx_axis_aresetn),
        .wr_en           (meta_wr),
        .wr_data         (meta_wr_data),
        .rd_en           (meta_rd),
        .rd_data         (meta_rd_data),
        .empty           (meta_empty),
        .almost_full     (meta_afull)
    );

    udp_tx_ctrl i_tx_ctrl (
        .tx_axis_aclk    (tx_axis_aclk),
        .tx_axis_aresetn (tx_axis_aresetn),
        .meta_empty      (meta_empty),
        .meta_data       (meta_rd_data),
        .meta_rd         (meta_rd),
        .beat_empty      (beat_empty),
        .beat_data       (beat_rd_data),
        .beat_rd         (beat_rd),
        .udp_src_port    (udp_src_port),
        .udp_dst_port    (udp_dst_port),
        .out_data        (ip_tx_axis_tdata),
        .out_keep        (ip_tx_axis_tkeep),
        .out_valid       (ip_tx_axis_tvalid),
        .out_last        (ip_tx_axis_tlast),
        .out_ready       (ip_tx_axis_tready)
    );

endmodule

// File: verilog/udp_tx_ctrl.sv
`timescale 1ns/1ps

module udp_tx_ctrl (
    input  logic                           tx_axis_aclk,
    input  logic                           tx_axis_aresetn,
    input  logic                           meta_empty,
    input  udp_tx_pkg::udp_meta_t          meta_data,
    output logic                           meta_rd,
    input  logic                           beat_empty,
    input  udp_tx_pkg::payload_beat_t      beat_data,
    output logic                           beat_rd,
    input  logic [15:0]                    udp_src_port,
    input  logic [15:0]                    udp_dst_port,
    output logic [udp_tx_pkg::DATA_W-1:0]  out_data,
    output logic [udp_tx_pkg::KEEP_W-1:0]  out_keep,
    output logic                           out_valid,
    output logic                           out_last,
    input  logic                           out_ready
);
    import udp_tx_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_PAYLOAD
    } state_t;

    state_t            state;
    udp_meta_t         meta_q;
    logic [DATA_W-1:0] hdr_data;
    logic              out_fire;

    // lane 0 first on the wire, so big-endian fields go in byte-swapped
    assign hdr_data = {meta_q.csum[7:0],   meta_q.csum[15:8],
                       meta_q.len[7:0],    meta_q.len[15:8],
                       udp_dst_port[7:0],  udp_dst_port[15:8],
                       udp_src_port[7:0],  udp_src_port[15:8]};

    assign meta_rd  = (state == ST_IDLE) & ~meta_empty;
    assign out_fire = out_valid & out_ready;
    assign beat_rd  = (state == ST_PAYLOAD) & out_fire;

    always_comb begin
        out_data  = '0;
        out_keep  = '0;
        out_valid = 1'b0;
        out_last  = 1'b0;
        case (state)
            ST_HEADER: begin
                out_data  = hdr_data;
                out_keep  = '1;
                out_valid = 1'b1;
            end
            ST_PAYLOAD: begin
                // head of the fifo holds still until popped
                out_data  = beat_data.data;
                out_keep  = beat_data.keep;
                out_valid = ~beat_empty;
                out_last  = ~beat_empty & beat_data.last;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge tx_axis_aclk) begin
        if (meta_rd) begin
            meta_q <= meta_data;
        end
    end

    always_ff @(posedge tx_axis_aclk) begin
        if (!tx_axis_aresetn) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (!meta_empty) begin
                        state <= ST_HEADER;
                    end
                end
                ST_HEADER: begin
                    if (out_ready) begin
                        state <= ST_PAYLOAD;
                    end
                end
                ST_PAYLOAD: begin
                    // back to idle gives the gap between packets
                    if (out_fire && out_last) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// File: verilog/udp_csum_finish.sv
`timescale 1ns/1ps

module udp_csum_finish (
    input  logic                           tx_axis_aclk,
    input  logic                           tx_axis_aresetn,
    input  logic                           sum_valid,
    input  logic [udp_tx_pkg::CSUM_W-1:0]  pay_sum,
    input  logic [udp_tx_pkg::LEN_W-1:0]   pay_len,
    input  logic [31:0]                    src_ip_addr,
    input  logic [31:0]                    dst_ip_addr,
    input  logic [15:0]                    udp_src_port,
    input  logic [15:0]                    udp_dst_port,
    output logic                           meta_wr,
    output udp_tx_pkg::udp_meta_t          meta_data
);
    import udp_tx_pkg::*;

    logic [LEN_W-1:0]  udp_len;

    logic              s1_valid;
    logic [LEN_W-1:0]  s1_len;
    logic [CSUM_W-1:0] s1_src;
    logic [CSUM_W-1:0] s1_dst;
    logic [CSUM_W-1:0] s1_len2;
    logic [CSUM_W-1:0] s1_ports;
    logic [CSUM_W-1:0] s1_pay;

    logic              s2_valid;
    logic [LEN_W-1:0]  s2_len;
    logic [CSUM_W-1:0] s2_ip;
    logic [CSUM_W-1:0] s2_rest;
    logic [CSUM_W-1:0] s2_pay;

    // udp header is part of the length
    assign udp_len = pay_len + LEN_W'(UDP_HDR_BYTES);

    always_ff @(posedge tx_axis_aclk) begin
        if (!tx_axis_aresetn) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            meta_wr  <= 1'b0;
        end else begin
            s1_valid <= sum_valid;
            s2_valid <= s1_valid;
            meta_wr  <= s2_valid;
        end
    end

    // stage 1: pairwise terms
    always_ff @(posedge tx_axis_aclk) begin
        if (sum_valid) begin
            s1_len   <= udp_len;
            s1_src   <= csum_add(src_ip_addr[31:16], src_ip_addr[15:0]);
            s1_dst   <= csum_add(dst_ip_addr[31:16], dst_ip_addr[15:0]);
            // length appears in the pseudo-header and in the udp header
            s1_len2  <= csum_add(udp_len, udp_len);
            s1_ports <= csum_add(udp_src_port, udp_dst_port);
            s1_pay   <= csum_add(pay_sum, CSUM_W'(UDP_PROTO));
        end
    end

    // stage 2
    always_ff @(posedge tx_axis_aclk) begin
        if (s1_valid) begin
            s2_len  <= s1_len;
            s2_ip   <= csum_add(s1_src, s1_dst);
            s2_rest <= csum_add(s1_len2, s1_ports);
            s2_pay  <= s1_pay;
        end
    end

    // stage 3: final sum, complemented
    always_ff @(posedge tx_axis_aclk) begin
        if (s2_valid) begin
            meta_data.len  <= s2_len;
            meta_data.csum <= ~csum_add(csum_add(s2_ip, s2_rest), s2_pay);
        end
    end

endmodule

// File: verilog/udp_csum_accum.sv
`timescale 1ns/1ps

module udp_csum_accum (
    input  logic                           tx_axis_aclk,
    input  logic                           tx_axis_aresetn,
    input  logic                           beat_fire,
    input  logic                           last_fire,
    input  logic [udp_tx_pkg::DATA_W-1:0]  in_data,
    input  logic [udp_tx_pkg::KEEP_W-1:0]  in_keep,
    input  logic [udp_tx_pkg::LEN_W-1:0]   pkt_len,
    output logic                           sum_valid,
    output logic [udp_tx_pkg::CSUM_W-1:0]  pay_sum,
    output logic [udp_tx_pkg::LEN_W-1:0]   pay_len
);
    import udp_tx_pkg::*;

    // one 16-bit word per even/odd lane pair
    localparam int PAIRS = KEEP_W / 2;

    logic [CSUM_W-1:0] part_sum  [PAIRS];
    logic [CSUM_W-1:0] lane_word [PAIRS];
    logic [CSUM_W-1:0] next_sum  [PAIRS];
    logic [CSUM_W-1:0] fold_lo;
    logic [CSUM_W-1:0] fold_hi;
    logic [CSUM_W-1:0] fold;

    // even lane is the high byte, missing lanes read as zero
    always_comb begin
        for (int i = 0; i < PAIRS; i++) begin
            lane_word[i][15:8] = in_keep[2*i]     ? in_data[16*i +: 8]     : 8'h00;
            lane_word[i][7:0]  = in_keep[2*i + 1] ? in_data[16*i + 8 +: 8] : 8'h00;
            next_sum[i]        = csum_add(part_sum[i], lane_word[i]);
        end
    end

    // collapse the four partials at packet end
    assign fold_lo = csum_add(next_sum[0], next_sum[1]);
    assign fold_hi = csum_add(next_sum[2], next_sum[3]);
    assign fold    = csum_add(fold_lo, fold_hi);

    always_ff @(posedge tx_axis_aclk) begin
        if (!tx_axis_aresetn) begin
            sum_valid <= 1'b0;
            for (int i = 0; i < PAIRS; i++) begin
                part_sum[i] <= '0;
            end
        end else begin
            sum_valid <= last_fire;
            if (beat_fire) begin
                for (int i = 0; i < PAIRS; i++) begin
                    // start fresh after the last beat
                    part_sum[i] <= last_fire ? '0 : next_sum[i];
                end
            end
        end
    end

    always_ff @(posedge tx_axis_aclk) begin
        if (last_fire) begin
            pay_sum <= fold;
            pay_len <= pkt_len;
        end
    end

endmodule

// File: verilog/udp_len_counter.sv
`timescale 1ns/1ps

module udp_len_counter (
    input  logic                           tx_axis_aclk,
    input  logic                           tx_axis_aresetn,
    input  logic                           in_valid,
    input  logic                           in_last,
    input  logic [udp_tx_pkg::KEEP_W-1:0]  in_keep,
    input  logic                           mac_exist,
    input  logic                           payload_afull,
    input  logic                           meta_afull,
    output logic                           in_ready,
    output logic                           beat_fire,
    output logic                           last_fire,
    output logic [udp_tx_pkg::LEN_W-1:0]   pkt_len
);
    import udp_tx_pkg::*;

    localparam int BYTES_W = $clog2(KEEP_W + 1);

    logic [LEN_W-1:0]   byte_cnt;
    logic [BYTES_W-1:0] beat_bytes;

    // stall the source when no mac or either buffer is close to full
    assign in_ready  = mac_exist & ~payload_afull & ~meta_afull;
    assign beat_fire = in_valid & in_ready;
    assign last_fire = beat_fire & in_last;

    // bytes in this beat
    always_comb begin
        beat_bytes = '0;
        for (int i = 0; i < KEEP_W; i++) begin
            beat_bytes = beat_bytes + BYTES_W'(in_keep[i]);
        end
    end

    // total including the current beat, meaningful on last_fire
    assign pkt_len = byte_cnt + LEN_W'(beat_bytes);

    always_ff @(posedge tx_axis_aclk) begin
        if (!tx_axis_aresetn) begin
            byte_cnt <= '0;
        end else if (beat_fire) begin
            if (in_last) begin
                byte_cnt <= '0;
            end else begin
                byte_cnt <= pkt_len;
            end
        end
    end

endmodule

// File: verilog/udp_sync_fifo.sv
`timescale 1ns/1ps

module udp_sync_fifo #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 16
) (
    input  logic   tx_axis_aclk,
    input  logic   tx_axis_aresetn,
    input  logic   wr_en,
    input  entry_t wr_data,
    input  logic   rd_en,
    output entry_t rd_data,
    output logic   empty,
    output logic   almost_full
);
    import udp_tx_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    entry_t             mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               full;
    logic               do_wr;
    logic               do_rd;

    assign full        = (count == CNT_W'(DEPTH));
    assign empty       = (count == '0);
    assign almost_full = (count >= CNT_W'(DEPTH - FIFO_AFULL_MARGIN));

    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & ~empty;

    // first word falls through
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge tx_axis_aclk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge tx_axis_aclk) begin
        if (!tx_axis_aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: verilog/udp_tx_pkg.sv
package udp_tx_pkg;

    // stream geometry
    localparam int DATA_W = 64;
    localparam int KEEP_W = 8;

    // udp fields
    localparam int CSUM_W            = 16;
    localparam int LEN_W             = 16;
    localparam int UDP_HDR_BYTES     = 8;
    localparam int UDP_PROTO         = 17;
    localparam int MAX_PAYLOAD_BYTES = 1472;

    // buffering
    localparam int PAYLOAD_FIFO_DEPTH = 256;
    localparam int META_FIFO_DEPTH    = 16;
    localparam int FIFO_AFULL_MARGIN  = 4;

    // one stored payload beat, 73 bits
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              last;
    } payload_beat_t;

    // per-packet record handed to the output side
    typedef struct packed {
        logic [LEN_W-1:0]  len;
        logic [CSUM_W-1:0] csum;
    } udp_meta_t;

    // ones'-complement add with end-around carry
    function automatic logic [CSUM_W-1:0] csum_add(
        input logic [CSUM_W-1:0] a,
        input logic [CSUM_W-1:0] b
    );
        logic [CSUM_W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        // carry folds back in, cannot overflow again
        return sum[CSUM_W-1:0] + {{(CSUM_W-1){1'b0}}, sum[CSUM_W]};
    endfunction

endpackage
